//--- run_sim.sh
#!/bin/sh
# build the counter testbench with verilator and run it from the project root
cd "$(dirname "$0")" &&
verilator --binary --timing --timescale 1ns/1ns -f verilog.f --top-module tb_cpu -o tb_cpu &&
./obj_dir/tb_cpu | tee /dev/stderr | grep -q "Simulation passed" &&
echo "run ok" ||
{ echo "run failed"; exit 1; }

//--- source/alu.sv
// operand selection and the byte alu with carry out
`timescale 1ns/1ns

module alu import cpu_pkg::*; (
    input  src_e    src_a,
    input  src_e    src_b,
    input  byte_t   immed,
    input  byte_t   rega,
    input  byte_t   regb,
    input  byte_t   rx_byte,
    input  logic    carry,
    input  alu_op_e alu_op,
    output byte_t   alu_result,
    output logic    alu_carry
);

    byte_t      opnd_a;
    byte_t      opnd_b;
    logic [8:0] sum;

    // operand muxes, same source set on both sides
    always_comb begin
        unique case (src_a)
            src_rega:  opnd_a = rega;
            src_regb:  opnd_a = regb;
            src_uart:  opnd_a = rx_byte;
            src_immed: opnd_a = immed;
            default:   opnd_a = rega;
        endcase
    end

    always_comb begin
        unique case (src_b)
            src_rega:  opnd_b = rega;
            src_regb:  opnd_b = regb;
            src_uart:  opnd_b = rx_byte;
            src_immed: opnd_b = immed;
            default:   opnd_b = regb;
        endcase
    end

    // one 9 bit adder shared by all sum ops
    // bit 8 is the carry out
    always_comb begin
        unique case (alu_op)
            op_a_plus_b:        sum = {1'b0, opnd_a} + {1'b0, opnd_b};
            op_a_plus_b_plus_c: sum = {1'b0, opnd_a} + {1'b0, opnd_b} + {8'd0, carry};
            op_b_plus_1:        sum = {1'b0, opnd_b} + 9'd1;
            op_b:               sum = {1'b0, opnd_b};
            default:            sum = {1'b0, opnd_a};
        endcase
    end

    // pass ops leave carry out at zero
    assign alu_result = sum[7:0];
    assign alu_carry  = sum[8];

endmodule

//--- source/counter_program.hex
// one 32 bit instruction word per line, rom address 0 first
// word fields msb first: cond, alu_op, dest, src_a, src_b, immed, jump_addr, reserved
00700000 // 0  rega <= 0
00B00000 // 1  regb <= 0
00F00000 // 2  marlo <= 0
01300000 // 3  marhi <= 0
40000034 // 4  loop, rx_full jumps to 13
6000002C // 5  tx_ready jumps to 11
044C0400 // 6  increment, rega <= rega + 1
069C0000 // 7  regb <= regb + 0 + carry
01100000 // 8  marhi <= regb
00C00000 // 9  marlo <= rega
20000010 // 10 back to loop
01400000 // 11 write, uart <= rega
20000018 // 12 on to increment
01200000 // 13 read, marhi <= uart byte
20000018 // 14 on to increment

//--- source/cpu_control.sv
// phase fsm, program counter, instruction register, carry flag, jumps and write strobes
`timescale 1ns/1ns

module cpu_control import cpu_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  instr_t     rom_word,
    input  byte_t      alu_result,
    input  logic       alu_carry,
    input  logic       rx_full,
    input  logic       tx_ready,
    output pc_t        pc,
    output alu_op_e    alu_op,
    output src_e       src_a,
    output src_e       src_b,
    output byte_t      immed,
    output logic       carry,
    output reg_write_t wr,
    output logic       rx_take
);

    phase_e phase;
    pc_t    pc_q;
    pc_t    pc_next;
    instr_t ir;
    logic   jump_taken;
    logic   arith_op;

    ////////////////////////////////////////////////////////////////////////////
    // sequencer
    ////////////////////////////////////////////////////////////////////////////

    // fetch and exec simply alternate
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phase <= ph_fetch;
        end else begin
            phase <= (phase == ph_fetch) ? ph_exec : ph_fetch;
        end
    end

    // rom output holds the word at pc all through fetch
    // latch it at the end of fetch
    always_ff @(posedge clk) begin
        if (phase == ph_fetch) begin
            ir <= rom_word;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // jumps and program counter
    ////////////////////////////////////////////////////////////////////////////

    // condition from flags as they stand during exec
    always_comb begin
        unique case (ir.cond)
            cond_never:    jump_taken = 1'b0;
            cond_always:   jump_taken = 1'b1;
            cond_rx_full:  jump_taken = rx_full;
            cond_tx_ready: jump_taken = tx_ready;
            cond_carry:    jump_taken = carry;
            default:       jump_taken = 1'b0;
        endcase
    end

    // pc only moves at the closing edge of exec
    always_comb begin
        pc_next = pc_q;
        if (phase == ph_exec) begin
            pc_next = jump_taken ? ir.jump_addr : pc_q + 8'd1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc_q <= '0;
        end else begin
            pc_q <= pc_next;
        end
    end

    // rom is addressed ahead with the pc the next edge will load
    // so the word is ready at the start of fetch
    assign pc = pc_next;

    ////////////////////////////////////////////////////////////////////////////
    // carry flag
    ////////////////////////////////////////////////////////////////////////////

    // only the adders touch the carry
    assign arith_op = (ir.alu_op == op_a_plus_b) ||
                      (ir.alu_op == op_a_plus_b_plus_c) ||
                      (ir.alu_op == op_b_plus_1);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            carry <= 1'b0;
        end else if (phase == ph_exec && arith_op) begin
            carry <= alu_carry;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // datapath controls
    ////////////////////////////////////////////////////////////////////////////

    assign alu_op = ir.alu_op;
    assign src_a  = ir.src_a;
    assign src_b  = ir.src_b;
    assign immed  = ir.immed;

    // write request valid in exec only
    always_comb begin
        wr.dest = dest_none;
        wr.data = alu_result;
        if (phase == ph_exec) begin
            wr.dest = ir.dest;
        end
    end

    // reading the uart byte frees the receive buffer
    assign rx_take = (phase == ph_exec) &&
                     ((ir.src_a == src_uart) || (ir.src_b == src_uart));

endmodule

//--- source/cpu_pkg.sv
// data widths, opcode enums, instruction and write request structs, rom size
package cpu_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // widths
    ////////////////////////////////////////////////////////////////////////////

    // one byte on the data buses, registers and uart
    typedef logic [7:0]  byte_t;
    // marhi:marlo as seen on the address bus
    typedef logic [15:0] addr16_t;
    // program counter, also the jump target
    typedef logic [7:0]  pc_t;

    // program rom size in instruction words
    localparam int unsigned rom_depth = 256;
    // rom image, path relative to the run directory
    localparam string rom_file = "source/counter_program.hex";

    ////////////////////////////////////////////////////////////////////////////
    // instruction field encodings
    ////////////////////////////////////////////////////////////////////////////

    typedef enum logic [3:0] {
        op_a               = 4'd0,
        op_b               = 4'd1,
        op_a_plus_b        = 4'd2,
        op_a_plus_b_plus_c = 4'd3,
        op_b_plus_1        = 4'd4
    } alu_op_e;

    // where the alu result goes
    typedef enum logic [2:0] {
        dest_none  = 3'd0,
        dest_rega  = 3'd1,
        dest_regb  = 3'd2,
        dest_marlo = 3'd3,
        dest_marhi = 3'd4,
        dest_uart  = 3'd5
    } dest_e;

    // operand sources, same set for both alu inputs
    typedef enum logic [1:0] {
        src_rega  = 2'd0,
        src_regb  = 2'd1,
        src_uart  = 2'd2,
        src_immed = 2'd3
    } src_e;

    // jump condition, tested in exec
    typedef enum logic [2:0] {
        cond_never    = 3'd0,
        cond_always   = 3'd1,
        cond_rx_full  = 3'd2,
        cond_tx_ready = 3'd3,
        cond_carry    = 3'd4
    } cond_e;

    // one rom word, msb first
    typedef struct packed {
        cond_e     cond;       // [31:29]
        alu_op_e   alu_op;     // [28:25]
        dest_e     dest;       // [24:22]
        src_e      src_a;      // [21:20]
        src_e      src_b;      // [19:18]
        byte_t     immed;      // [17:10]
        pc_t       jump_addr;  // [9:2]
        logic [1:0] reserved;  // [1:0] kept zero
    } instr_t;

    // two phase sequencer
    typedef enum logic {
        ph_fetch = 1'b0,
        ph_exec  = 1'b1
    } phase_e;

    // write request from control to register file and uart
    typedef struct packed {
        dest_e dest;
        byte_t data;
    } reg_write_t;

endpackage

//--- source/cpu_top.sv
// processor top with control, rom, alu, register file and uart port
`timescale 1ns/1ns

module cpu_top import cpu_pkg::*; (
    input  logic    clk,
    input  logic    rst_n,
    input  logic    rx_strobe,
    input  byte_t   rx_data,
    input  logic    tx_ready,
    output logic    tx_strobe,
    output byte_t   tx_data,
    output addr16_t mar
);

    // control to datapath
    pc_t        pc;
    alu_op_e    alu_op;
    src_e       src_a;
    src_e       src_b;
    byte_t      immed;
    logic       carry;
    reg_write_t wr;
    logic       rx_take;

    // datapath back to control
    instr_t     rom_word;
    byte_t      alu_result;
    logic       alu_carry;
    logic       rx_full;

    // operand buses
    byte_t      rega;
    byte_t      regb;
    byte_t      rx_byte;

    ////////////////////////////////////////////////////////////////////////////
    // sequencer and program store
    ////////////////////////////////////////////////////////////////////////////

    cpu_control u_control (
        .clk        (clk),
        .rst_n      (rst_n),
        .rom_word   (rom_word),
        .alu_result (alu_result),
        .alu_carry  (alu_carry),
        .rx_full    (rx_full),
        .tx_ready   (tx_ready),
        .pc         (pc),
        .alu_op     (alu_op),
        .src_a      (src_a),
        .src_b      (src_b),
        .immed      (immed),
        .carry      (carry),
        .wr         (wr),
        .rx_take    (rx_take)
    );

    program_rom u_rom (
        .clk      (clk),
        .pc       (pc),
        .rom_word (rom_word)
    );

    ////////////////////////////////////////////////////////////////////////////
    // datapath
    ////////////////////////////////////////////////////////////////////////////

    alu u_alu (
        .src_a      (src_a),
        .src_b      (src_b),
        .immed      (immed),
        .rega       (rega),
        .regb       (regb),
        .rx_byte    (rx_byte),
        .carry      (carry),
        .alu_op     (alu_op),
        .alu_result (alu_result),
        .alu_carry  (alu_carry)
    );

    register_file u_regs (
        .clk   (clk),
        .rst_n (rst_n),
        .wr    (wr),
        .rega  (rega),
        .regb  (regb),
        .mar   (mar)
    );

    // same write request feeds the uart transmit side
    uart_port u_uart (
        .clk       (clk),
        .rst_n     (rst_n),
        .wr        (wr),
        .rx_strobe (rx_strobe),
        .rx_data   (rx_data),
        .rx_take   (rx_take),
        .rx_full   (rx_full),
        .rx_byte   (rx_byte),
        .tx_strobe (tx_strobe),
        .tx_data   (tx_data)
    );

endmodule

//--- source/program_rom.sv
// instruction rom loaded from the program image, registered read port
`timescale 1ns/1ns

module program_rom import cpu_pkg::*; (
    input  logic   clk,
    input  pc_t    pc,
    output instr_t rom_word
);

    // raw words as they sit in the hex image
    logic [31:0] rom_mem [rom_depth];

    // program is fixed, loaded once at start
    initial begin
        $readmemh(rom_file, rom_mem);
    end

    // synchronous read, one word per clock
    // pc indexes all 256 words directly
    always_ff @(posedge clk) begin
        rom_word <= instr_t'(rom_mem[pc]);
    end

endmodule

//--- source/register_file.sv
// general registers rega and regb, address registers marlo and marhi
`timescale 1ns/1ns

module register_file import cpu_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  reg_write_t wr,
    output byte_t      rega,
    output byte_t      regb,
    output addr16_t    mar
);

    byte_t marlo;
    byte_t marhi;

    // one register per write, picked by dest
    // dest_none and dest_uart fall through untouched
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rega  <= '0;
            regb  <= '0;
            marlo <= '0;
            marhi <= '0;
        end else begin
            unique case (wr.dest)
                dest_rega:  rega  <= wr.data;
                dest_regb:  regb  <= wr.data;
                dest_marlo: marlo <= wr.data;
                dest_marhi: marhi <= wr.data;
                default: begin
                    // not a register file destination
                end
            endcase
        end
    end

    // address bus, high byte first
    assign mar = {marhi, marlo};

endmodule

//--- source/uart_port.sv
// uart receive buffer with full flag, transmit register with one cycle strobe
`timescale 1ns/1ns

module uart_port import cpu_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  reg_write_t wr,
    input  logic       rx_strobe,
    input  byte_t      rx_data,
    input  logic       rx_take,
    output logic       rx_full,
    output byte_t      rx_byte,
    output logic       tx_strobe,
    output byte_t      tx_data
);

    logic rx_load;
    logic tx_load;

    ////////////////////////////////////////////////////////////////////////////
    // receive side
    ////////////////////////////////////////////////////////////////////////////

    // only an empty buffer accepts a byte
    // a byte arriving while full is dropped
    assign rx_load = rx_strobe && !rx_full;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rx_full <= 1'b0;
        end else if (rx_load) begin
            rx_full <= 1'b1;
        end else if (rx_take) begin
            rx_full <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rx_load) begin
            rx_byte <= rx_data;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // transmit side
    ////////////////////////////////////////////////////////////////////////////

    assign tx_load = (wr.dest == dest_uart);

    // strobe follows the exec write by one edge
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tx_strobe <= 1'b0;
        end else begin
            tx_strobe <= tx_load;
        end
    end

    // data stays put until the next uart write
    always_ff @(posedge clk) begin
        if (tx_load) begin
            tx_data <= wr.data;
        end
    end

endmodule

//--- testbench/tb_cpu.sv
// testbench for cpu_top with clock, reset, uart stimulus, reference counter and compares
`timescale 1ns/1ns

module tb_cpu import cpu_pkg::*; ();

    ////////////////////////////////////////////////////////////////////////////
    // dut hookup
    ////////////////////////////////////////////////////////////////////////////

    logic    clk;
    logic    rst_n;
    logic    rx_strobe;
    byte_t   rx_data;
    logic    tx_ready;
    logic    tx_strobe;
    byte_t   tx_data;
    addr16_t mar;

    // random stream for tx_ready and rx bytes
    integer  seed;

    // model state written only by the monitor
    addr16_t count             = '0;
    addr16_t mar_prev          = '0;
    int      incr_count        = 0;
    int      tx_count          = 0;
    int      rx_taken          = 0;
    logic    wrap_seen         = 1'b0;
    logic    ready_since_write = 1'b0;
    logic    strobe_prev       = 1'b0;

    // receive bookkeeping written only by the stimulus
    int      rx_sent           = 0;
    byte_t   rx_expect         = '0;

    cpu_top UUT (
        .clk       (clk),
        .rst_n     (rst_n),
        .rx_strobe (rx_strobe),
        .rx_data   (rx_data),
        .tx_ready  (tx_ready),
        .tx_strobe (tx_strobe),
        .tx_data   (tx_data),
        .mar       (mar)
    );

    // 40 ns period
    always #20 clk = ~clk;

    ////////////////////////////////////////////////////////////////////////////
    // reference model and compares
    ////////////////////////////////////////////////////////////////////////////

    // 16 bit counter step where ffff rolls over to 0000
    function automatic addr16_t next_count(input addr16_t value);
        return value + 16'd1;
    endfunction

    // second rx byte that differs from the first and from both likely marhi values
    function automatic byte_t pick_dropped(input byte_t first, input byte_t hi_a,
                                           input byte_t hi_b);
        byte_t candidate;
        candidate = first ^ 8'h55;
        if (candidate == hi_a || candidate == hi_b) begin
            candidate = first ^ 8'haa;
        end
        if (candidate == hi_a || candidate == hi_b) begin
            candidate = first ^ 8'h0f;
        end
        return candidate;
    endfunction

    task automatic stop_with_error(input string what);
        $display("%s", what);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic check_mar(input addr16_t actual, input addr16_t expected);
        if (actual !== expected) begin
            stop_with_error($sformatf("Fail at %0t ns: mar = %h, expected %h",
                                      $time, actual, expected));
        end
    endtask

    task automatic check_tx(input byte_t actual, input byte_t expected);
        if (actual !== expected) begin
            stop_with_error($sformatf("Fail at %0t ns: tx_data = %h, expected %h",
                                      $time, actual, expected));
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // monitor samples mid cycle where outputs are settled
    ////////////////////////////////////////////////////////////////////////////

    always @(negedge clk) begin : monitor
        addr16_t expected;
        if (rst_n) begin
            // one transmit pulse per allowed write
            if (tx_strobe) begin
                if (strobe_prev) begin
                    stop_with_error("tx_strobe stayed high for more than one cycle");
                end
                if (!ready_since_write) begin
                    stop_with_error("tx_strobe pulsed while tx_ready was low since last write");
                end
                check_tx(tx_data, count[7:0]);
                tx_count++;
                ready_since_write = 1'b0;
            end
            if (tx_ready) begin
                ready_since_write = 1'b1;
            end
            strobe_prev = tx_strobe;

            // only changes of the address bus count as events
            expected = next_count(count);
            if (mar != mar_prev) begin
                if (mar[7:0] != mar_prev[7:0]) begin
                    // marlo write closes an increment
                    check_mar(mar, expected);
                    count = expected;
                    incr_count++;
                    if (count == 16'h0000) begin
                        wrap_seen = 1'b1;
                    end
                end else if (rx_sent != rx_taken) begin
                    // pending rx byte lands in marhi
                    check_mar(mar, {rx_expect, count[7:0]});
                    rx_taken++;
                end else begin
                    // marhi takes the new count high byte
                    check_mar(mar, {expected[15:8], count[7:0]});
                end
                mar_prev = mar;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // bounded waits
    ////////////////////////////////////////////////////////////////////////////

    task automatic wait_increments(input int n, input int max_cycles);
        int start;
        int cycles;
        start  = incr_count;
        cycles = 0;
        while (incr_count - start < n) begin
            @(posedge clk);
            #2;
            cycles++;
            if (cycles > max_cycles) begin
                stop_with_error($sformatf("timeout: count did not advance %0d steps", n));
            end
        end
    endtask

    task automatic wait_wrap(input int max_cycles);
        int cycles;
        cycles = 0;
        while (!wrap_seen) begin
            @(posedge clk);
            #2;
            cycles++;
            if (cycles > max_cycles) begin
                stop_with_error("timeout: count never wrapped from ffff to 0000");
            end
        end
    endtask

    task automatic wait_strobes(input int n, input int max_cycles);
        int start;
        int cycles;
        start  = tx_count;
        cycles = 0;
        while (tx_count - start < n) begin
            @(posedge clk);
            #2;
            cycles++;
            if (cycles > max_cycles) begin
                stop_with_error($sformatf("timeout: fewer than %0d tx strobes seen", n));
            end
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////////////////////////////////////////

    // random levels held for 1 to 16 cycles
    task automatic toggle_ready(input int cycles);
        logic [31:0] rnd;
        int          hold;
        int          done;
        done = 0;
        while (done < cycles) begin
            rnd      = $random(seed);
            tx_ready = rnd[0];
            hold     = int'(rnd[7:4]) + 1;
            repeat (hold) begin
                @(posedge clk);
                #2;
            end
            done += hold;
        end
    endtask

    // one rx byte and a second one while the buffer is still full
    task automatic send_rx_pair();
        logic [31:0] rnd;
        addr16_t     upcoming;
        byte_t       first;
        byte_t       dropped;
        int          start;
        int          cycles;
        // line up right behind a finished increment so the loop polls rx first
        start  = incr_count;
        cycles = 0;
        while (incr_count == start) begin
            @(posedge clk);
            #2;
            cycles++;
            if (cycles > 400) begin
                stop_with_error("timeout: no increment before sending rx byte");
            end
        end
        upcoming = next_count(count);
        rnd      = $random(seed);
        first    = rnd[7:0];
        // same value as marhi would leave mar unchanged
        if (first == mar[15:8]) begin
            first = first ^ 8'h80;
        end
        dropped   = pick_dropped(first, mar[15:8], upcoming[15:8]);
        rx_expect = first;
        rx_sent++;
        rx_data   = first;
        rx_strobe = 1'b1;
        @(posedge clk);
        #2;
        // buffer is full here so this byte must vanish
        rx_data = dropped;
        @(posedge clk);
        #2;
        rx_strobe = 1'b0;
        rx_data   = '0;
        cycles    = 0;
        while (rx_taken != rx_sent) begin
            @(posedge clk);
            #2;
            cycles++;
            if (cycles > 200) begin
                stop_with_error("timeout: received byte never showed up in marhi");
            end
        end
    endtask

    initial begin
        int incr_before;
        int tx_before;
        seed      = 32'h9cee;
        clk       = 1'b0;
        rst_n     = 1'b0;
        rx_strobe = 1'b0;
        rx_data   = '0;
        tx_ready  = 1'b0;
        repeat (2) @(posedge clk);
        #2;
        rst_n = 1'b1;
        check_mar(mar, 16'h0000);

        // quiet port runs the count through the full wrap
        wait_wrap(1_200_000);
        wait_increments(16, 400);
        if (tx_count != 0) begin
            stop_with_error("tx_strobe pulsed while tx_ready was held low");
        end

        // every loop pass now writes the count out
        tx_ready = 1'b1;
        wait_strobes(32, 2000);

        // random back pressure
        incr_before = incr_count;
        tx_before   = tx_count;
        toggle_ready(6000);
        if (incr_count - incr_before < 100) begin
            stop_with_error("counting stalled under random tx_ready");
        end
        if (tx_count == tx_before) begin
            stop_with_error("no byte was sent under random tx_ready");
        end

        // receive path with transmit held off
        tx_ready = 1'b0;
        repeat (8) send_rx_pair();
        wait_increments(16, 400);

        $display("Simulation passed");
        $finish;
    end

endmodule

//--- verilog.f
source/cpu_pkg.sv
source/program_rom.sv
source/alu.sv
source/register_file.sv
source/uart_port.sv
source/cpu_control.sv
source/cpu_top.sv
testbench/tb_cpu.sv
